// ==== logic/execPkg.sv ====
package execPkg;

    // Datapath widths.
    localparam int xlen = 64;
    localparam int wordWidth = 32;
    localparam int regIdWidth = 5;
    localparam int memModeWidth = 3;
    localparam int shamtWidth = $clog2(xlen);
    localparam int wordShamtWidth = $clog2(wordWidth);

    // Radix-16 multiplier, one digit per step.
    localparam int mulDigitWidth = 4;
    localparam int mulSteps = xlen / mulDigitWidth;
    localparam int mulCountWidth = $clog2(mulSteps);

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOpT;

    // High variants differ only in operand signedness.
    typedef enum logic [1:0] {
        mulMul    = 2'd0,
        mulMulh   = 2'd1,
        mulMulhu  = 2'd2,
        mulMulhsu = 2'd3
    } mulOpT;

    typedef enum logic [1:0] {
        srcAZero    = 2'd0,
        srcARs1     = 2'd1,
        srcAPc      = 2'd2,
        srcAPcPlus4 = 2'd3
    } srcAT;

    typedef enum logic [1:0] {
        srcBRs2      = 2'd0,
        srcBImm      = 2'd1,
        srcBImmUpper = 2'd2
    } srcBT;

    typedef enum logic [1:0] {
        resAlu64   = 2'd0,
        resAlu32   = 2'd1,
        resMul     = 2'd2,
        resCompare = 2'd3
    } resultSelT;

    typedef enum logic [1:0] {
        flagLessSigned   = 2'd0,
        flagLessUnsigned = 2'd1,
        flagEqual        = 2'd2
    } flagSelT;

    typedef enum logic [1:0] {
        mulIdle   = 2'd0,
        mulRun    = 2'd1,
        mulFinish = 2'd2
    } mulState;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu import execPkg::*; (
    input  logic [xlen-1:0]      ia,
    input  logic [xlen-1:0]      ib,
    input  aluOpT                aluOp,
    output logic [xlen-1:0]      result,
    output logic [wordWidth-1:0] result32,
    output logic                 lessSigned,
    output logic                 lessUnsigned,
    output logic                 equal
);

    logic [shamtWidth-1:0] shamt;
    logic [wordShamtWidth-1:0] wordShamt;
    logic [wordWidth-1:0] wa;
    logic [wordWidth-1:0] wb;

    assign shamt = ib[shamtWidth-1:0];
    assign wordShamt = ib[wordShamtWidth-1:0];
    assign wa = ia[wordWidth-1:0];
    assign wb = ib[wordWidth-1:0];

    // Signs differ, so the negative operand is the smaller one.
    assign lessUnsigned = ia < ib;
    assign lessSigned = (ia[xlen-1] != ib[xlen-1]) ? ia[xlen-1] : lessUnsigned;
    assign equal = ia == ib;

    always_comb begin
        case (aluOp)
            aluAdd:  result = ia + ib;
            aluSub:  result = ia - ib;
            aluSll:  result = ia << shamt;
            aluSlt:  result = {{(xlen-1){1'b0}}, lessSigned};
            aluSltu: result = {{(xlen-1){1'b0}}, lessUnsigned};
            aluXor:  result = ia ^ ib;
            aluSrl:  result = ia >> shamt;
            aluSra:  result = $signed(ia) >>> shamt;
            aluOr:   result = ia | ib;
            aluAnd:  result = ia & ib;
            default: result = '0;
        endcase
    end

    // Word forms shift by five bits only.
    always_comb begin
        case (aluOp)
            aluAdd:  result32 = wa + wb;
            aluSub:  result32 = wa - wb;
            aluSll:  result32 = wa << wordShamt;
            aluSrl:  result32 = wa >> wordShamt;
            aluSra:  result32 = $signed(wa) >>> wordShamt;
            default: result32 = result[wordWidth-1:0];
        endcase
    end

endmodule

// ==== logic/multiplier.sv ====
`timescale 1ns/1ns

module multiplier import execPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  mulOpT           mulOp,
    input  logic [xlen-1:0] ia,
    input  logic [xlen-1:0] ib,
    output logic            busy,
    output logic            done,
    output logic [xlen-1:0] product
);

    mulState state;
    logic [mulCountWidth-1:0] count;
    mulOpT opReg;
    logic negResult;
    logic [xlen-1:0] mcand;
    logic [2*xlen-1:0] acc;

    logic aSigned;
    logic bSigned;
    logic [xlen-1:0] magA;
    logic [xlen-1:0] magB;
    logic [xlen-1:0] stepCand;
    logic [xlen-1:0] stepHi;
    logic [xlen-1:0] stepLo;
    logic [xlen+mulDigitWidth-1:0] stepSum;
    logic [2*xlen-1:0] accNext;
    logic [2*xlen-1:0] signedAcc;

    assign aSigned = (mulOp == mulMulh) || (mulOp == mulMulhsu);
    assign bSigned = mulOp == mulMulh;
    assign magA = (aSigned && ia[xlen-1]) ? -ia : ia;
    assign magB = (bSigned && ib[xlen-1]) ? -ib : ib;

    // First digit is taken straight from the operands on start.
    assign stepCand = (state == mulIdle) ? magA : mcand;
    assign stepHi = (state == mulIdle) ? '0 : acc[2*xlen-1:xlen];
    assign stepLo = (state == mulIdle) ? magB : acc[xlen-1:0];

    // Add one digit product, then shift the pair right by a digit.
    assign stepSum = {{mulDigitWidth{1'b0}}, stepHi}
                   + stepCand * stepLo[mulDigitWidth-1:0];
    assign accNext = {stepSum, stepLo[xlen-1:mulDigitWidth]};

    assign signedAcc = negResult ? -acc : acc;
    assign busy = state != mulIdle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mulIdle;
            count <= '0;
            done <= 1'b0;
        end else begin
            case (state)
                mulIdle: begin
                    if (start) begin
                        state <= mulRun;
                        count <= mulCountWidth'(1);
                        done <= 1'b0;
                    end
                end
                mulRun: begin
                    if (count == mulCountWidth'(mulSteps - 1)) begin
                        state <= mulFinish;
                    end
                    count <= count + 1'b1;
                end
                mulFinish: begin
                    state <= mulIdle;
                    done <= 1'b1;
                end
                default: state <= mulIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mulIdle && start) begin
            opReg <= mulOp;
            negResult <= (aSigned && ia[xlen-1]) ^ (bSigned && ib[xlen-1]);
            mcand <= magA;
            acc <= accNext;
        end else if (state == mulRun) begin
            acc <= accNext;
        end

        // Held until the next start.
        if (state == mulFinish) begin
            product <= (opReg == mulMul) ? signedAcc[xlen-1:0] : signedAcc[2*xlen-1:xlen];
        end
    end

endmodule

// ==== logic/operandBypass.sv ====
`timescale 1ns/1ns

module operandBypass import execPkg::*; (
    input  logic [regIdWidth-1:0] rs1Id,
    input  logic [regIdWidth-1:0] rs2Id,
    input  logic [xlen-1:0]       rs1Val,
    input  logic [xlen-1:0]       rs2Val,
    input  logic                  exValid,
    input  logic                  exWbEn,
    input  logic [regIdWidth-1:0] exWd,
    input  logic [xlen-1:0]       exResult,
    input  logic                  memFwdValid,
    input  logic [regIdWidth-1:0] memFwdWd,
    input  logic [xlen-1:0]       memFwdData,
    output logic [xlen-1:0]       rs1,
    output logic [xlen-1:0]       rs2
);

    // Youngest producer wins.
    function automatic logic [xlen-1:0] resolve(
        input logic [regIdWidth-1:0] id,
        input logic [xlen-1:0]       regVal
    );
        logic [xlen-1:0] value;
        if (id == '0) begin
            value = '0;
        end else if (exValid && exWbEn && exWd == id) begin
            value = exResult;
        end else if (memFwdValid && memFwdWd == id) begin
            value = memFwdData;
        end else begin
            value = regVal;
        end
        return value;
    endfunction

    always_comb begin
        rs1 = resolve(rs1Id, rs1Val);
        rs2 = resolve(rs2Id, rs2Val);
    end

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ns

module executeStage import execPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    inValid,
    input  logic [xlen-1:0]         pc,
    input  logic [xlen-1:0]         rs1,
    input  logic [xlen-1:0]         rs2,
    input  logic [xlen-1:0]         imm,
    input  srcAT                    srcA,
    input  srcBT                    srcB,
    input  aluOpT                   aluOp,
    input  mulOpT                   mulOp,
    input  resultSelT               resultSel,
    input  flagSelT                 flagSel,
    input  logic                    flagInv,
    input  logic                    wbEn,
    input  logic [regIdWidth-1:0]   wd,
    input  logic                    isBranch,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic [memModeWidth-1:0] memMode,
    output logic                    ready,
    output logic                    exValid,
    output logic [xlen-1:0]         exResult,
    output logic [xlen-1:0]         exRs2,
    output logic [regIdWidth-1:0]   exWd,
    output logic                    exWbEn,
    output logic                    exBranchTaken,
    output logic [xlen-1:0]         exPcBranch,
    output logic                    exMemRead,
    output logic                    exMemWrite,
    output logic [memModeWidth-1:0] exMemMode
);

    logic [xlen-1:0] ia;
    logic [xlen-1:0] ib;
    logic [xlen-1:0] aluResult;
    logic [wordWidth-1:0] aluResult32;
    logic lessSigned;
    logic lessUnsigned;
    logic equal;
    logic flag;
    logic compareBit;
    logic [xlen-1:0] result;
    logic [xlen-1:0] mulProduct;
    logic mulBusy;
    logic mulDone;
    logic mulStart;
    logic productUsed;
    logic isMul;
    logic mulAvail;
    logic accept;

    always_comb begin
        case (srcA)
            srcAZero:    ia = '0;
            srcARs1:     ia = rs1;
            srcAPc:      ia = pc;
            srcAPcPlus4: ia = pc + xlen'(4);
            default:     ia = '0;
        endcase
        case (srcB)
            srcBRs2:      ib = rs2;
            srcBImm:      ib = imm;
            srcBImmUpper: ib = imm << 12;
            default:      ib = '0;
        endcase
    end

    alu u_alu (
        .ia(ia),
        .ib(ib),
        .aluOp(aluOp),
        .result(aluResult),
        .result32(aluResult32),
        .lessSigned(lessSigned),
        .lessUnsigned(lessUnsigned),
        .equal(equal)
    );

    multiplier u_multiplier (
        .clk(clk),
        .rst(rst),
        .start(mulStart),
        .mulOp(mulOp),
        .ia(ia),
        .ib(ib),
        .busy(mulBusy),
        .done(mulDone),
        .product(mulProduct)
    );

    always_comb begin
        case (flagSel)
            flagLessSigned:   flag = lessSigned;
            flagLessUnsigned: flag = lessUnsigned;
            flagEqual:        flag = equal;
            default:          flag = 1'b0;
        endcase
    end
    assign compareBit = flag ^ flagInv;

    always_comb begin
        case (resultSel)
            resAlu64:   result = aluResult;
            resAlu32:   result = {{(xlen-wordWidth){aluResult32[wordWidth-1]}}, aluResult32};
            resMul:     result = mulProduct;
            resCompare: result = {{(xlen-1){1'b0}}, compareBit};
            default:    result = aluResult;
        endcase
    end

    // A multiply waits until its own product is done and not yet consumed.
    assign isMul = inValid && resultSel == resMul;
    assign mulAvail = mulDone && !productUsed;
    assign mulStart = isMul && !mulBusy && !mulAvail && !stall;
    assign ready = !isMul || mulAvail;
    assign accept = inValid && ready && !stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            productUsed <= 1'b0;
            exValid <= 1'b0;
            exWbEn <= 1'b0;
            exBranchTaken <= 1'b0;
            exMemRead <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            if (mulStart) begin
                productUsed <= 1'b0;
            end else if (accept && isMul) begin
                productUsed <= 1'b1;
            end
            // Bubbles clear the control bits.
            if (!stall) begin
                exValid <= accept;
                exWbEn <= accept && wbEn;
                exBranchTaken <= accept && isBranch && compareBit;
                exMemRead <= accept && memRead;
                exMemWrite <= accept && memWrite;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exResult <= result;
            exRs2 <= rs2;
            exWd <= wd;
            exPcBranch <= pc + imm;
            exMemMode <= memMode;
        end
    end

endmodule

// ==== logic/executeCore.sv ====
`timescale 1ns/1ns

module executeCore import execPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inValid,
    input  logic [xlen-1:0]         pc,
    input  logic [regIdWidth-1:0]   rs1Id,
    input  logic [regIdWidth-1:0]   rs2Id,
    input  logic [xlen-1:0]         rs1Val,
    input  logic [xlen-1:0]         rs2Val,
    input  logic [xlen-1:0]         imm,
    input  srcAT                    srcA,
    input  srcBT                    srcB,
    input  aluOpT                   aluOp,
    input  mulOpT                   mulOp,
    input  resultSelT               resultSel,
    input  flagSelT                 flagSel,
    input  logic                    flagInv,
    input  logic                    wbEn,
    input  logic [regIdWidth-1:0]   wd,
    input  logic                    isBranch,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic [memModeWidth-1:0] memMode,
    input  logic                    memFwdValid,
    input  logic [regIdWidth-1:0]   memFwdWd,
    input  logic [xlen-1:0]         memFwdData,
    input  logic                    stall,
    output logic                    ready,
    output logic                    exValid,
    output logic [xlen-1:0]         exResult,
    output logic [xlen-1:0]         exRs2,
    output logic [regIdWidth-1:0]   exWd,
    output logic                    exWbEn,
    output logic                    exBranchTaken,
    output logic [xlen-1:0]         exPcBranch,
    output logic                    exMemRead,
    output logic                    exMemWrite,
    output logic [memModeWidth-1:0] exMemMode
);

    logic [xlen-1:0] rs1Fwd;
    logic [xlen-1:0] rs2Fwd;

    // EX/MEM outputs loop back as the nearest forward source.
    operandBypass u_operandBypass (
        .rs1Id(rs1Id),
        .rs2Id(rs2Id),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .exValid(exValid),
        .exWbEn(exWbEn),
        .exWd(exWd),
        .exResult(exResult),
        .memFwdValid(memFwdValid),
        .memFwdWd(memFwdWd),
        .memFwdData(memFwdData),
        .rs1(rs1Fwd),
        .rs2(rs2Fwd)
    );

    executeStage u_executeStage (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .inValid(inValid),
        .pc(pc),
        .rs1(rs1Fwd),
        .rs2(rs2Fwd),
        .imm(imm),
        .srcA(srcA),
        .srcB(srcB),
        .aluOp(aluOp),
        .mulOp(mulOp),
        .resultSel(resultSel),
        .flagSel(flagSel),
        .flagInv(flagInv),
        .wbEn(wbEn),
        .wd(wd),
        .isBranch(isBranch),
        .memRead(memRead),
        .memWrite(memWrite),
        .memMode(memMode),
        .ready(ready),
        .exValid(exValid),
        .exResult(exResult),
        .exRs2(exRs2),
        .exWd(exWd),
        .exWbEn(exWbEn),
        .exBranchTaken(exBranchTaken),
        .exPcBranch(exPcBranch),
        .exMemRead(exMemRead),
        .exMemWrite(exMemWrite),
        .exMemMode(exMemMode)
    );

endmodule

// ==== verification/executeCoreTb.sv ====
`timescale 1ns/1ns

module executeCoreTb import execPkg::*; ();

    localparam int maxTests = 64;
    localparam int numCols = 25;

    logic clk = 1'b0;
    logic rst;
    logic inValid;
    logic [xlen-1:0] pc;
    logic [regIdWidth-1:0] rs1Id;
    logic [regIdWidth-1:0] rs2Id;
    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] rs2Val;
    logic [xlen-1:0] imm;
    srcAT srcA;
    srcBT srcB;
    aluOpT aluOp;
    mulOpT mulOp;
    resultSelT resultSel;
    flagSelT flagSel;
    logic flagInv;
    logic wbEn;
    logic [regIdWidth-1:0] wd;
    logic isBranch;
    logic memRead;
    logic memWrite;
    logic [memModeWidth-1:0] memMode;
    logic memFwdValid;
    logic [regIdWidth-1:0] memFwdWd;
    logic [xlen-1:0] memFwdData;
    logic stall;
    logic ready;
    logic exValid;
    logic [xlen-1:0] exResult;
    logic [xlen-1:0] exRs2;
    logic [regIdWidth-1:0] exWd;
    logic exWbEn;
    logic exBranchTaken;
    logic [xlen-1:0] exPcBranch;
    logic exMemRead;
    logic exMemWrite;
    logic [memModeWidth-1:0] exMemMode;

    // Columns: see the data file.
    logic [63:0] vec [maxTests][numCols];
    string names [maxTests];
    int numTests;
    int curIdx;

    executeCore i_dut (.*);

    always #4 clk = ~clk;

    task automatic checkValue(input string field, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s %s expected %h actual %h", names[curIdx], field,
                     expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Check failed.");
        end
    endtask

    task automatic readTests();
        int fd;
        int n;
        string line;
        string nm;
        logic [63:0] f [numCols];
        fd = $fopen("verification/executeTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test vector file.");
            $display("*** FAILED ***");
            $fatal(1, "No vectors.");
        end
        numTests = 0;
        while (!$feof(fd) && numTests < maxTests) begin
            if ($fgets(line, fd) && line.len() > 2 && line[0] != "#") begin
                n = $sscanf(line,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    nm, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                    f[21], f[22], f[23], f[24]);
                if (n == numCols + 1) begin
                    names[numTests] = nm;
                    vec[numTests] = f;
                    numTests++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic driveTest(input int i);
        srcA <= srcAT'(vec[i][0][1:0]);
        srcB <= srcBT'(vec[i][1][1:0]);
        aluOp <= aluOpT'(vec[i][2][3:0]);
        mulOp <= mulOpT'(vec[i][3][1:0]);
        resultSel <= resultSelT'(vec[i][4][1:0]);
        flagSel <= flagSelT'(vec[i][5][1:0]);
        flagInv <= vec[i][6][0];
        isBranch <= vec[i][7][0];
        memRead <= vec[i][8][0];
        memWrite <= vec[i][9][0];
        memMode <= vec[i][10][memModeWidth-1:0];
        wbEn <= vec[i][11][0];
        wd <= vec[i][12][regIdWidth-1:0];
        rs1Id <= vec[i][13][regIdWidth-1:0];
        rs2Id <= vec[i][14][regIdWidth-1:0];
        pc <= vec[i][15];
        imm <= vec[i][16];
        rs1Val <= vec[i][17];
        rs2Val <= vec[i][18];
        memFwdValid <= vec[i][19][0];
        memFwdWd <= vec[i][20][regIdWidth-1:0];
        memFwdData <= vec[i][21];
        inValid <= 1'b1;
    endtask

    task automatic checkOutputs(input int i);
        curIdx = i;
        checkValue("exValid", 1, exValid);
        checkValue("exResult", vec[i][22], exResult);
        checkValue("exRs2", vec[i][23], exRs2);
        checkValue("exBranchTaken", vec[i][24], exBranchTaken);
        // Target rule is pc plus imm.
        checkValue("exPcBranch", vec[i][15] + vec[i][16], exPcBranch);
        checkValue("exWbEn", vec[i][11], exWbEn);
        checkValue("exWd", vec[i][12], exWd);
        checkValue("exMemRead", vec[i][8], exMemRead);
        checkValue("exMemWrite", vec[i][9], exMemWrite);
        checkValue("exMemMode", vec[i][10], exMemMode);
    endtask

    initial begin
        int seed;
        int issued;
        int checked;
        int cycles;
        int acceptedIdx;
        logic accepted;
        logic wasStalled;
        logic sawBusy;
        seed = $urandom(10873);
        {rst, inValid, stall, flagInv, wbEn, isBranch, memRead, memWrite} = '1;
        {inValid, stall, flagInv, wbEn, isBranch, memRead, memWrite} = '0;
        {pc, rs1Id, rs2Id, rs1Val, rs2Val, imm, wd, memMode} = '0;
        {memFwdValid, memFwdWd, memFwdData} = '0;
        srcA = srcAZero;
        srcB = srcBRs2;
        aluOp = aluAdd;
        mulOp = mulMul;
        resultSel = resAlu64;
        flagSel = flagEqual;
        sawBusy = 1'b0;
        readTests();
        if (numTests == 0) begin
            $display("The test vector file holds no tests.");
            $display("*** FAILED ***");
            $fatal(1, "No vectors.");
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        driveTest(0);
        issued = 0;
        checked = 0;
        cycles = 0;
        while (checked < numTests) begin
            @(posedge clk);
            cycles++;
            if (cycles > 40 * numTests) begin
                $display("Timeout: results stopped arriving after %0d of %0d.",
                         checked, numTests);
                $display("*** FAILED ***");
                $fatal(1, "Timeout.");
            end
            // Values seen here are those before the edge.
            accepted = inValid && ready && !stall;
            wasStalled = stall;
            acceptedIdx = issued;
            if (inValid) begin
                curIdx = acceptedIdx;
                if (vec[acceptedIdx][4][1:0] == resMul) begin
                    if (!ready) begin
                        sawBusy = 1'b1;
                    end
                    if (accepted) begin
                        // A multiply holds the stage before its product is ready.
                        checkValue("readyLow", 1, sawBusy);
                        sawBusy = 1'b0;
                    end
                end else begin
                    checkValue("ready", 1, ready);
                end
            end
            if (accepted) begin
                issued++;
                if (issued < numTests) begin
                    driveTest(issued);
                end else begin
                    inValid <= 1'b0;
                end
            end
            stall <= ($urandom % 4) == 0;
            @(negedge clk);
            if (accepted) begin
                checkOutputs(acceptedIdx);
                checked++;
            end else if (!wasStalled) begin
                // A bubble must not repeat the previous result.
                curIdx = acceptedIdx < numTests ? acceptedIdx : numTests - 1;
                checkValue("exValid", 0, exValid);
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verification/executeTests.txt ====
# name sa sb alu mul rsel fsel inv br rd wr mode wb wd r1 r2 pc imm v1 v2 fv fwd fdata
# then expected result, expected exRs2, expected branch taken (all hex)
add 1 0 0 0 0 0 0 0 0 0 0 1 01 02 03 100 0 5 7 0 0 0 c 7 0
sub 1 0 1 0 0 0 0 0 0 0 0 1 02 02 03 104 0 5 7 0 0 0 fffffffffffffffe 7 0
sll 1 0 2 0 0 0 0 0 0 0 0 1 03 04 06 108 0 1 3f 0 0 0 8000000000000000 3f 0
sra 1 0 7 0 0 0 0 0 0 0 0 1 07 08 09 10c 0 8000000000000000 4 0 0 0 f800000000000000 4 0
xor 1 0 5 0 0 0 0 0 0 0 0 1 0b 0c 0d 110 0 ff00 ff0 0 0 0 f0f0 ff0 0
and 1 0 9 0 0 0 0 0 0 0 0 1 0e 0c 0d 114 0 ff00 ff0 0 0 0 f00 ff0 0
addw 1 0 0 0 1 0 0 0 0 0 0 1 10 0c 0d 118 0 7fffffff 1 0 0 0 ffffffff80000000 1 0
sraw 1 0 7 0 1 0 0 0 0 0 0 1 11 0c 0d 11c 0 80000000 24 0 0 0 fffffffff8000000 24 0
auipc 2 2 0 0 0 0 0 0 0 0 0 1 12 00 00 1000 5 0 0 0 0 0 6000 0 0
jal 3 1 0 0 0 2 1 1 0 0 0 1 13 00 00 2000 0 0 0 0 0 0 2004 0 1
slt 1 0 0 0 3 0 0 0 0 0 0 1 14 16 17 124 0 ffffffffffffffff 1 0 0 0 1 1 0
sltu 1 0 0 0 3 1 0 0 0 0 0 1 15 16 17 128 0 ffffffffffffffff 1 0 0 0 0 1 0
sgeu 1 0 0 0 3 1 1 0 0 0 0 1 18 16 17 12c 0 ffffffffffffffff 1 0 0 0 1 1 0
seq 1 0 0 0 3 2 0 0 0 0 0 1 19 16 17 130 0 5 5 0 0 0 1 5 0
beq 1 0 0 0 0 2 0 1 0 0 0 0 00 16 17 3000 40 9 9 0 0 0 12 9 1
blt 1 0 0 0 0 0 0 1 0 0 0 0 00 16 17 3040 20 5 ffffffffffffffff 0 0 0 4 ffffffffffffffff 0
store 1 1 0 0 0 0 0 0 0 1 3 0 00 16 17 3100 8 1000 abcd 0 0 0 1008 abcd 0
load 1 1 0 0 0 0 0 0 1 0 4 1 05 16 00 3104 10 2000 0 0 0 0 2010 0 0
mul 1 1 0 0 2 0 0 0 0 0 0 1 06 16 00 3108 ffffffffffffffff 8000000000000000 0 0 0 0 8000000000000000 0 0
mulh 1 1 0 1 2 0 0 0 0 0 0 1 07 16 00 310c ffffffffffffffff 8000000000000000 0 0 0 0 0 0 0
mulhu 1 1 0 2 2 0 0 0 0 0 0 1 08 16 00 3110 ffffffffffffffff 8000000000000000 0 0 0 0 7fffffffffffffff 0 0
mulhsu 1 1 0 3 2 0 0 0 0 0 0 1 09 16 00 3114 ffffffffffffffff 8000000000000000 0 0 0 0 8000000000000000 0 0
fwdEx 1 1 0 0 0 0 0 0 0 0 0 1 0a 09 00 3118 2 0 0 0 0 0 8000000000000002 0 0
fwdMem 1 1 0 0 0 0 0 0 0 0 0 1 0d 0c 00 311c 1 1 0 1 0c 100 101 0 0
exWins 1 1 0 0 0 0 0 0 0 0 0 1 0e 0d 00 3120 1 5 0 1 0d 999 102 0 0
fwdRs2 1 0 0 0 0 0 0 0 0 0 0 1 00 00 0e 3124 0 0 5 0 0 0 102 102 0
zeroReg 1 0 0 0 0 0 0 0 0 0 0 1 1f 00 00 3128 0 77 88 1 00 55 0 0 0

// ==== executeCore.f ====
logic/execPkg.sv
logic/alu.sv
logic/multiplier.sv
logic/operandBypass.sv
logic/executeStage.sv
logic/executeCore.sv
verification/executeCoreTb.sv

// ==== Bender.yml ====
package:
  name: executeCore

sources:
  - logic/execPkg.sv
  - logic/alu.sv
  - logic/multiplier.sv
  - logic/operandBypass.sv
  - logic/executeStage.sv
  - logic/executeCore.sv
  - target: test
    files:
      - verification/executeCoreTb.sv
